//--- all.f
+incdir+common
common/adam_bus_pkg.sv
common/adam_ctrl_pkg.sv
common/adam_apb_if.sv
syscfg/adam_pause_seq.sv
syscfg/adam_syscfg.sv
periph/adam_periph_gpio.sv
periph/adam_periph_timer.sv
source/adam_apb_demux.sv
source/adam_lsp.sv
tests/adam_lsp_chk.sv
tests/adam_lsp_tb.sv

//--- common/adam_apb_if.sv
// apb link between the demux and the blocks behind it, with manager and subordinate views
interface adam_apb_if import adam_bus_pkg::*; ();

    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_u paddr;
    data_t pwdata;
    data_t prdata;
    logic  pready;
    logic  pslverr;

    modport mgr (
        output psel,
        output penable,
        output pwrite,
        output paddr,
        output pwdata,
        input  prdata,
        input  pready,
        input  pslverr
    );

    modport sub (
        input  psel,
        input  penable,
        input  pwrite,
        input  paddr,
        input  pwdata,
        output prdata,
        output pready,
        output pslverr
    );

endinterface

//--- common/adam_bus_pkg.sv
// apb word types shared by the top level, the demux, the peripherals and the testbench
`include "adam_defs.svh"

package adam_bus_pkg;

    typedef logic [`ADAM_DATA_WIDTH-1:0] data_t;

    typedef logic [`ADAM_SLOT_IDX_WIDTH-1:0] slot_idx_t;
    typedef logic [`ADAM_ADDR_WIDTH-`ADAM_SLOT_IDX_WIDTH-1:0] offset_t;

    // demux looks at idx, peripherals look at offset
    typedef struct packed {
        slot_idx_t idx;
        offset_t   offset;
    } addr_fields_t;

    typedef union packed {
        logic [`ADAM_ADDR_WIDTH-1:0] raw;
        addr_fields_t                fields;
    } addr_u;

endpackage

//--- common/adam_ctrl_pkg.sv
// slot numbering and pause sequencer states, used by the demux, syscfg and the testbench
`include "adam_defs.svh"

package adam_ctrl_pkg;

    // slot index as seen in the upper address bits
    typedef enum logic [`ADAM_SLOT_IDX_WIDTH-1:0] {
        SLOT_SYSCFG   = 0,
        SLOT_GPIO     = 1,
        SLOT_TIMER    = 2,
        SLOT_UNMAPPED = 3
    } slot_e;

    // encoding is visible in the syscfg status register
    typedef enum logic [2:0] {
        RUN      = 3'd0,
        PAUSING  = 3'd1,
        PAUSED   = 3'd2,
        RESET    = 3'd3,
        RESUMING = 3'd4
    } pause_state_e;

endpackage

//--- common/adam_defs.svh
// width and count macros for the low-speed domain, included by packages and modules that size ports
`ifndef ADAM_DEFS_SVH
`define ADAM_DEFS_SVH

// apb data and address word widths
`define ADAM_DATA_WIDTH 32
`define ADAM_ADDR_WIDTH 12

// upper address bits select the peripheral slot
`define ADAM_SLOT_IDX_WIDTH 4

// gpio pins on the single gpio peripheral
`define ADAM_NO_GPIO_PINS 8

// slots behind the demux, last one is unmapped
`define ADAM_NO_SLOTS 4

`endif

//--- periph/adam_periph_gpio.sv
// gpio peripheral with output, direction and synchronized input registers on apb
`include "adam_defs.svh"

module adam_periph_gpio import adam_bus_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic rst,

    adam_apb_if.sub apb,

    input  logic pause_req,
    output logic pause_ack,

    input  logic [`ADAM_NO_GPIO_PINS-1:0] gpio_in,
    output logic [`ADAM_NO_GPIO_PINS-1:0] gpio_out,
    output logic [`ADAM_NO_GPIO_PINS-1:0] gpio_oe
);

    logic [`ADAM_NO_GPIO_PINS-1:0] out_q;
    logic [`ADAM_NO_GPIO_PINS-1:0] oe_q;
    logic [`ADAM_NO_GPIO_PINS-1:0] in_meta_q;
    logic [`ADAM_NO_GPIO_PINS-1:0] in_sync_q;

    logic  access;
    logic  err;
    logic  ack_q;
    data_t rdata;

    assign access = apb.psel && apb.penable;

    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (apb.paddr.fields.offset)
            offset_t'('h00): rdata = data_t'(out_q);
            offset_t'('h04): rdata = data_t'(oe_q);
            offset_t'('h08): begin
                rdata = data_t'(in_sync_q);
                err   = apb.pwrite;
            end
            default: err = 1'b1;
        endcase
        // nothing readable while held in local reset
        if (err || rst) begin
            rdata = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q <= '0;
            oe_q  <= '0;
        end else if (rst) begin
            out_q <= '0;
            oe_q  <= '0;
        end else if (access && apb.pwrite && !err) begin
            case (apb.paddr.fields.offset)
                offset_t'('h00): out_q <= apb.pwdata[`ADAM_NO_GPIO_PINS-1:0];
                offset_t'('h04): oe_q  <= apb.pwdata[`ADAM_NO_GPIO_PINS-1:0];
                default: ;
            endcase
        end
    end

    // two-flop input synchronizer
    always_ff @(posedge clk) begin
        in_meta_q <= gpio_in;
        in_sync_q <= in_meta_q;
    end

    // nothing in flight, so quiescent right away
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= pause_req;
        end
    end

    assign apb.pready  = access;
    assign apb.pslverr = access && err;
    assign apb.prdata  = rdata;

    assign pause_ack = ack_q;
    assign gpio_out  = out_q;
    assign gpio_oe   = oe_q;

endmodule

//--- periph/adam_periph_timer.sv
// free-running compare timer on apb, raises irq when the count hits the compare value
module adam_periph_timer import adam_bus_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic rst,

    adam_apb_if.sub apb,

    input  logic pause_req,
    output logic pause_ack,

    output logic irq
);

    logic  enable_q;
    data_t compare_q;
    data_t count_q;
    logic  pending_q;
    logic  ack_q;

    logic  access;
    logic  wr;
    logic  err;
    logic  run;
    logic  hit;
    data_t rdata;

    assign access = apb.psel && apb.penable;
    assign wr     = access && apb.pwrite && !err;

    // frozen as soon as the pause request shows up
    assign run = enable_q && !pause_req;
    assign hit = run && (count_q == compare_q);

    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (apb.paddr.fields.offset)
            offset_t'('h00): rdata[0] = enable_q;
            offset_t'('h04): rdata = compare_q;
            offset_t'('h08): begin
                rdata = count_q;
                err   = apb.pwrite;
            end
            offset_t'('h0c): rdata[0] = pending_q;
            default: err = 1'b1;
        endcase
        if (err || rst) begin
            rdata = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q  <= 1'b0;
            compare_q <= '0;
            count_q   <= '0;
            pending_q <= 1'b0;
        end else if (rst) begin
            enable_q  <= 1'b0;
            compare_q <= '0;
            count_q   <= '0;
            pending_q <= 1'b0;
        end else begin
            if (hit) begin
                count_q <= '0;
            end else if (run) begin
                count_q <= count_q + 1'b1;
            end

            // a new hit wins over a clear in the same cycle
            if (hit) begin
                pending_q <= 1'b1;
            end else if (wr && apb.paddr.fields.offset == offset_t'('h0c) && apb.pwdata[0]) begin
                pending_q <= 1'b0;
            end

            if (wr && apb.paddr.fields.offset == offset_t'('h00)) begin
                enable_q <= apb.pwdata[0];
            end
            if (wr && apb.paddr.fields.offset == offset_t'('h04)) begin
                compare_q <= apb.pwdata;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= pause_req;
        end
    end

    assign apb.pready  = access;
    assign apb.pslverr = access && err;
    assign apb.prdata  = rdata;

    assign pause_ack = ack_q;
    assign irq       = pending_q;

endmodule

//--- run.sh
#!/bin/sh
# build and run the low-speed domain testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module adam_lsp_tb \
    -f all.f \
    -o adam_lsp_sim

./obj_dir/adam_lsp_sim

//--- source/adam_apb_demux.sv
// apb demux, routes one manager to the syscfg, gpio and timer slots by address index
module adam_apb_demux import adam_bus_pkg::*, adam_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst_n,

    adam_apb_if.sub mgr,

    adam_apb_if.mgr slot_syscfg,
    adam_apb_if.mgr slot_gpio,
    adam_apb_if.mgr slot_timer
);

    slot_e slot;
    logic  unmapped;
    logic  err_q;

    assign slot     = slot_e'(mgr.paddr.fields.idx);
    assign unmapped = !(slot inside {SLOT_SYSCFG, SLOT_GPIO, SLOT_TIMER});

    // psel goes to one slot only, the rest is broadcast
    assign slot_syscfg.psel    = mgr.psel && (slot == SLOT_SYSCFG);
    assign slot_syscfg.penable = mgr.penable;
    assign slot_syscfg.pwrite  = mgr.pwrite;
    assign slot_syscfg.paddr   = mgr.paddr;
    assign slot_syscfg.pwdata  = mgr.pwdata;

    assign slot_gpio.psel    = mgr.psel && (slot == SLOT_GPIO);
    assign slot_gpio.penable = mgr.penable;
    assign slot_gpio.pwrite  = mgr.pwrite;
    assign slot_gpio.paddr   = mgr.paddr;
    assign slot_gpio.pwdata  = mgr.pwdata;

    assign slot_timer.psel    = mgr.psel && (slot == SLOT_TIMER);
    assign slot_timer.penable = mgr.penable;
    assign slot_timer.pwrite  = mgr.pwrite;
    assign slot_timer.paddr   = mgr.paddr;
    assign slot_timer.pwdata  = mgr.pwdata;

    // remember an unmapped setup so the access cycle can answer with an error
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= mgr.psel && !mgr.penable && unmapped;
        end
    end

    always_comb begin
        mgr.prdata  = '0;
        mgr.pready  = mgr.psel && mgr.penable && err_q;
        mgr.pslverr = mgr.psel && mgr.penable && err_q;
        case (slot)
            SLOT_SYSCFG: begin
                mgr.prdata  = slot_syscfg.prdata;
                mgr.pready  = slot_syscfg.pready;
                mgr.pslverr = slot_syscfg.pslverr;
            end
            SLOT_GPIO: begin
                mgr.prdata  = slot_gpio.prdata;
                mgr.pready  = slot_gpio.pready;
                mgr.pslverr = slot_gpio.pslverr;
            end
            SLOT_TIMER: begin
                mgr.prdata  = slot_timer.prdata;
                mgr.pready  = slot_timer.pready;
                mgr.pslverr = slot_timer.pslverr;
            end
            default: begin
                // error response from err_q above
            end
        endcase
    end

endmodule

//--- source/adam_lsp.sv
// low-speed domain top level, takes one apb port and serves syscfg, gpio and timer behind it
`include "adam_defs.svh"

module adam_lsp import adam_bus_pkg::*; (
    input  logic clk,
    input  logic rst_n,

    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  addr_u paddr,
    input  data_t pwdata,
    output data_t prdata,
    output logic  pready,
    output logic  pslverr,

    input  logic [`ADAM_NO_GPIO_PINS-1:0] gpio_in,
    output logic [`ADAM_NO_GPIO_PINS-1:0] gpio_out,
    output logic [`ADAM_NO_GPIO_PINS-1:0] gpio_oe,

    output logic timer_irq
);

    adam_apb_if apb_top ();
    adam_apb_if apb_syscfg ();
    adam_apb_if apb_gpio ();
    adam_apb_if apb_timer ();

    logic gpio_rst;
    logic gpio_pause_req;
    logic gpio_pause_ack;
    logic timer_rst;
    logic timer_pause_req;
    logic timer_pause_ack;

    // external apb port onto the fabric link
    assign apb_top.psel    = psel;
    assign apb_top.penable = penable;
    assign apb_top.pwrite  = pwrite;
    assign apb_top.paddr   = paddr;
    assign apb_top.pwdata  = pwdata;
    assign prdata          = apb_top.prdata;
    assign pready          = apb_top.pready;
    assign pslverr         = apb_top.pslverr;

    adam_apb_demux i_apb_demux (
        .clk         (clk),
        .rst_n       (rst_n),
        .mgr         (apb_top),
        .slot_syscfg (apb_syscfg),
        .slot_gpio   (apb_gpio),
        .slot_timer  (apb_timer)
    );

    adam_syscfg i_syscfg (
        .clk             (clk),
        .rst_n           (rst_n),
        .apb             (apb_syscfg),
        .gpio_rst        (gpio_rst),
        .gpio_pause_req  (gpio_pause_req),
        .gpio_pause_ack  (gpio_pause_ack),
        .timer_rst       (timer_rst),
        .timer_pause_req (timer_pause_req),
        .timer_pause_ack (timer_pause_ack)
    );

    adam_periph_gpio i_gpio (
        .clk       (clk),
        .rst_n     (rst_n),
        .rst       (gpio_rst),
        .apb       (apb_gpio),
        .pause_req (gpio_pause_req),
        .pause_ack (gpio_pause_ack),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .gpio_oe   (gpio_oe)
    );

    adam_periph_timer i_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .rst       (timer_rst),
        .apb       (apb_timer),
        .pause_req (timer_pause_req),
        .pause_ack (timer_pause_ack),
        .irq       (timer_irq)
    );

endmodule

//--- syscfg/adam_pause_seq.sv
// pause and reset sequencer for one peripheral, driven by the syscfg control bits
module adam_pause_seq import adam_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst_n,

    input  logic want_pause,
    input  logic want_reset,

    output logic pause_req,
    output logic periph_rst,
    input  logic pause_ack,

    output pause_state_e state
);

    pause_state_e state_q;
    pause_state_e state_d;
    logic         want;

    assign want = want_pause || want_reset;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RUN: begin
                if (want) state_d = PAUSING;
            end
            // hold the request until the peripheral is quiescent
            PAUSING: begin
                if (pause_ack) state_d = PAUSED;
            end
            PAUSED: begin
                if (want_reset) state_d = RESET;
                else if (!want_pause) state_d = RESUMING;
            end
            RESET: begin
                if (!want_reset) state_d = want_pause ? PAUSED : RESUMING;
            end
            RESUMING: begin
                if (!pause_ack) state_d = RUN;
            end
            default: state_d = RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // request already in the cycle after the control write
    always_comb begin
        case (state_q)
            RUN:      pause_req = want;
            PAUSING:  pause_req = 1'b1;
            PAUSED:   pause_req = 1'b1;
            RESET:    pause_req = 1'b1;
            default:  pause_req = 1'b0;
        endcase
    end

    assign periph_rst = (state_q == RESET);
    assign state      = state_q;

endmodule

//--- syscfg/adam_syscfg.sv
// system configuration block, holds per-peripheral reset and pause requests and reports sequencer state
module adam_syscfg import adam_bus_pkg::*, adam_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst_n,

    adam_apb_if.sub apb,

    output logic gpio_rst,
    output logic gpio_pause_req,
    input  logic gpio_pause_ack,

    output logic timer_rst,
    output logic timer_pause_req,
    input  logic timer_pause_ack
);

    // control word layout: bit 0 reset, bit 1 pause
    logic [1:0]   gpio_ctrl_q;
    logic [1:0]   timer_ctrl_q;
    pause_state_e gpio_state;
    pause_state_e timer_state;

    logic  access;
    logic  err;
    data_t rdata;

    assign access = apb.psel && apb.penable;

    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (apb.paddr.fields.offset)
            offset_t'('h00): rdata[1:0] = gpio_ctrl_q;
            offset_t'('h04): rdata[1:0] = timer_ctrl_q;
            offset_t'('h08): begin
                // status is read-only
                rdata[2:0] = gpio_state;
                rdata[6:4] = timer_state;
                err        = apb.pwrite;
            end
            default: err = 1'b1;
        endcase
        if (err) begin
            rdata = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_ctrl_q  <= '0;
            timer_ctrl_q <= '0;
        end else if (access && apb.pwrite && !err) begin
            case (apb.paddr.fields.offset)
                offset_t'('h00): gpio_ctrl_q  <= apb.pwdata[1:0];
                offset_t'('h04): timer_ctrl_q <= apb.pwdata[1:0];
                default: ;
            endcase
        end
    end

    // zero wait states
    assign apb.pready  = access;
    assign apb.pslverr = access && err;
    assign apb.prdata  = rdata;

    adam_pause_seq i_gpio_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .want_pause  (gpio_ctrl_q[1]),
        .want_reset  (gpio_ctrl_q[0]),
        .pause_req   (gpio_pause_req),
        .periph_rst  (gpio_rst),
        .pause_ack   (gpio_pause_ack),
        .state       (gpio_state)
    );

    adam_pause_seq i_timer_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .want_pause  (timer_ctrl_q[1]),
        .want_reset  (timer_ctrl_q[0]),
        .pause_req   (timer_pause_req),
        .periph_rst  (timer_rst),
        .pause_ack   (timer_pause_ack),
        .state       (timer_state)
    );

endmodule

//--- tests/adam_lsp_chk.sv
// apb and pause handshake assertions, bound into the low-speed top level
module adam_lsp_chk (
    input logic clk,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic gpio_pause_req,
    input logic gpio_pause_ack,
    input logic gpio_rst,
    input logic timer_pause_req,
    input logic timer_pause_ack,
    input logic timer_rst
);

    timeunit 1ns;
    timeprecision 100ps;

    // access phase needs a setup cycle before it
    a_penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> $past(psel && !penable))
        else $error("penable rose without a setup cycle");

    a_pready_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> psel)
        else $error("pready high without psel");

    a_gpio_ack_in_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(gpio_pause_ack) |-> gpio_pause_req)
        else $error("gpio pause_ack rose without pause_req");

    a_timer_ack_in_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(timer_pause_ack) |-> timer_pause_req)
        else $error("timer pause_ack rose without pause_req");

    // local reset only inside a pause
    a_gpio_rst_paused: assert property (@(posedge clk) disable iff (!rst_n)
        gpio_rst |-> gpio_pause_req)
        else $error("gpio reset high without pause_req");

    a_timer_rst_paused: assert property (@(posedge clk) disable iff (!rst_n)
        timer_rst |-> timer_pause_req)
        else $error("timer reset high without pause_req");

endmodule

bind adam_lsp adam_lsp_chk i_chk (
    .clk             (clk),
    .rst_n           (rst_n),
    .psel            (psel),
    .penable         (penable),
    .pready          (pready),
    .gpio_pause_req  (gpio_pause_req),
    .gpio_pause_ack  (gpio_pause_ack),
    .gpio_rst        (gpio_rst),
    .timer_pause_req (timer_pause_req),
    .timer_pause_ack (timer_pause_ack),
    .timer_rst       (timer_rst)
);

//--- tests/adam_lsp_tb.sv
// testbench for the low-speed domain, random apb traffic against a register model of gpio and timer
`include "adam_defs.svh"

module adam_lsp_tb import adam_bus_pkg::*, adam_ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 16;
    localparam int GPIO_OPS     = 40;
    localparam int ERR_OPS      = 16;
    // generous bound on all transfers including status polls
    localparam int MAX_TXNS     = 160;
    localparam int TXN_CYCLES   = 10;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_u paddr;
    data_t pwdata;
    data_t prdata;
    logic  pready;
    logic  pslverr;
    logic [`ADAM_NO_GPIO_PINS-1:0] gpio_in;
    logic [`ADAM_NO_GPIO_PINS-1:0] gpio_out;
    logic [`ADAM_NO_GPIO_PINS-1:0] gpio_oe;
    logic  timer_irq;

    logic [31:0] rng = 32'h3bc4cf5b;
    logic [`ADAM_NO_GPIO_PINS-1:0] m_out;
    logic [`ADAM_NO_GPIO_PINS-1:0] m_oe;

    adam_lsp i_adam_lsp (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .gpio_oe   (gpio_oe),
        .timer_irq (timer_irq)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift(rng);
        r = rng;
    endtask

    function automatic addr_u make_addr(input slot_e slot, input offset_t off);
        addr_u a;
        a.fields.idx    = slot;
        a.fields.offset = off;
        return a;
    endfunction

    task automatic stop_with_fail(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            stop_with_fail($sformatf("ERROR %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            stop_with_fail($sformatf("ERROR %s: expected pslverr %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_state(input string name, input pause_state_e exp,
                               input pause_state_e act);
        if (exp !== act) begin
            stop_with_fail($sformatf("ERROR %s: expected %s actual %s",
                                     name, exp.name(), act.name()));
        end
    endtask

    // setup cycle, access cycle, then wait for pready sampled mid-cycle
    task automatic apb_xfer(input logic wr, input addr_u addr, input data_t wdata,
                            output data_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_ok(input string name, input addr_u addr, input data_t wdata);
        data_t rd;
        logic  err;
        apb_xfer(1'b1, addr, wdata, rd, err);
        check_err(name, 1'b0, err);
    endtask

    task automatic read_check(input string name, input addr_u addr, input data_t exp);
        data_t rd;
        logic  err;
        apb_xfer(1'b0, addr, '0, rd, err);
        check_err(name, 1'b0, err);
        check_data(name, exp, rd);
    endtask

    task automatic expect_error(input string name, input logic wr, input addr_u addr);
        data_t rd;
        logic  err;
        apb_xfer(wr, addr, 32'hdead_beef, rd, err);
        check_err(name, 1'b1, err);
        if (!wr) begin
            check_data(name, '0, rd);
        end
    endtask

    // read status until the selected sequencer reaches the wanted state
    task automatic poll_state(input string name, input logic timer_sel,
                              input pause_state_e want, output data_t status);
        pause_state_e st;
        logic         err;
        do begin
            apb_xfer(1'b0, make_addr(SLOT_SYSCFG, 8'h08), '0, status, err);
            check_err(name, 1'b0, err);
            st = timer_sel ? pause_state_e'(status[6:4]) : pause_state_e'(status[2:0]);
        end while (st != want);
    endtask

    initial begin
        #((RESET_CYCLES + MAX_TXNS * TXN_CYCLES) * 2 * CLK_HALF);
        stop_with_fail("timeout: the tests did not finish in time");
    end

    initial begin
        logic [31:0] r;
        data_t       status;
        data_t       c1;
        data_t       c2;
        logic        rd_err;
        data_t       cmp;
        int          waited;

        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        gpio_in = '0;
        m_out   = '0;
        m_oe    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // gpio registers against the model
        for (int i = 0; i < GPIO_OPS; i++) begin
            next_rand(r);
            case (r[1:0])
                2'd0: begin
                    m_out = r[8 +: `ADAM_NO_GPIO_PINS];
                    write_ok("gpio write out", make_addr(SLOT_GPIO, 8'h00), data_t'(m_out));
                end
                2'd1: begin
                    m_oe = r[8 +: `ADAM_NO_GPIO_PINS];
                    write_ok("gpio write oe", make_addr(SLOT_GPIO, 8'h04), data_t'(m_oe));
                end
                2'd2: read_check("gpio read out", make_addr(SLOT_GPIO, 8'h00), data_t'(m_out));
                default: read_check("gpio read oe", make_addr(SLOT_GPIO, 8'h04), data_t'(m_oe));
            endcase
            @(negedge clk);
            check_data("gpio_out pins", data_t'(m_out), data_t'(gpio_out));
            check_data("gpio_oe pins", data_t'(m_oe), data_t'(gpio_oe));
        end
        for (int i = 0; i < 4; i++) begin
            next_rand(r);
            @(posedge clk);
            gpio_in <= r[`ADAM_NO_GPIO_PINS-1:0];
            repeat (3) @(posedge clk);
            read_check("gpio input sync", make_addr(SLOT_GPIO, 8'h08),
                       data_t'(r[`ADAM_NO_GPIO_PINS-1:0]));
        end

        // address errors
        expect_error("gpio write input reg", 1'b1, make_addr(SLOT_GPIO, 8'h08));
        expect_error("timer write count", 1'b1, make_addr(SLOT_TIMER, 8'h08));
        for (int i = 0; i < ERR_OPS; i++) begin
            next_rand(r);
            case (r[1:0])
                2'd0: expect_error("unmapped slot", r[8], make_addr(SLOT_UNMAPPED, r[23:16]));
                2'd1: expect_error("gpio bad offset", r[8],
                                   make_addr(SLOT_GPIO, r[23:16] | 8'h10));
                2'd2: expect_error("timer bad offset", r[8],
                                   make_addr(SLOT_TIMER, r[23:16] | 8'h10));
                default: expect_error("syscfg status write", 1'b1,
                                      make_addr(SLOT_SYSCFG, 8'h08));
            endcase
        end

        // pause the running timer
        write_ok("timer compare", make_addr(SLOT_TIMER, 8'h04), 32'h0010_0000);
        write_ok("timer enable", make_addr(SLOT_TIMER, 8'h00), 32'h1);
        repeat (5) @(posedge clk);
        write_ok("timer pause", make_addr(SLOT_SYSCFG, 8'h04), 32'h2);
        poll_state("timer paused", 1'b1, PAUSED, status);
        check_state("gpio still running", RUN, pause_state_e'(status[2:0]));
        read_check("timer pause bit", make_addr(SLOT_SYSCFG, 8'h04), 32'h2);
        apb_xfer(1'b0, make_addr(SLOT_TIMER, 8'h08), '0, c1, rd_err);
        check_err("timer paused count", 1'b0, rd_err);
        next_rand(r);
        repeat (4 + r % 8) @(posedge clk);
        read_check("timer frozen count", make_addr(SLOT_TIMER, 8'h08), c1);
        write_ok("timer unpause", make_addr(SLOT_SYSCFG, 8'h04), 32'h0);
        poll_state("timer resumed", 1'b1, RUN, status);
        apb_xfer(1'b0, make_addr(SLOT_TIMER, 8'h08), '0, c2, rd_err);
        check_err("timer resumed count", 1'b0, rd_err);
        if (!(c2 > c1)) begin
            stop_with_fail("timer count did not advance after the pause was released");
        end

        // local reset of the gpio
        next_rand(r);
        m_out = r[7:0] | 8'h01;
        m_oe  = r[15:8] | 8'h01;
        write_ok("gpio preset out", make_addr(SLOT_GPIO, 8'h00), data_t'(m_out));
        write_ok("gpio preset oe", make_addr(SLOT_GPIO, 8'h04), data_t'(m_oe));
        write_ok("gpio reset on", make_addr(SLOT_SYSCFG, 8'h00), 32'h1);
        poll_state("gpio in reset", 1'b0, RESET, status);
        check_state("timer still running", RUN, pause_state_e'(status[6:4]));
        @(negedge clk);
        check_data("gpio_out in reset", '0, data_t'(gpio_out));
        check_data("gpio_oe in reset", '0, data_t'(gpio_oe));
        write_ok("gpio write in reset", make_addr(SLOT_GPIO, 8'h00),
                 data_t'(r[23:16] | 8'h01));
        @(negedge clk);
        check_data("gpio_out write ignored", '0, data_t'(gpio_out));
        read_check("gpio read in reset", make_addr(SLOT_GPIO, 8'h00), '0);
        write_ok("gpio reset off", make_addr(SLOT_SYSCFG, 8'h00), 32'h0);
        poll_state("gpio out of reset", 1'b0, RUN, status);
        m_out = '0;
        m_oe  = '0;
        read_check("gpio out after reset", make_addr(SLOT_GPIO, 8'h00), data_t'(m_out));
        read_check("gpio oe after reset", make_addr(SLOT_GPIO, 8'h04), data_t'(m_oe));

        // timer interrupt, reset first so the count starts at zero
        write_ok("timer reset on", make_addr(SLOT_SYSCFG, 8'h04), 32'h1);
        poll_state("timer in reset", 1'b1, RESET, status);
        write_ok("timer reset off", make_addr(SLOT_SYSCFG, 8'h04), 32'h0);
        poll_state("timer out of reset", 1'b1, RUN, status);
        next_rand(r);
        cmp = data_t'(2 + r % 6);
        write_ok("timer small compare", make_addr(SLOT_TIMER, 8'h04), cmp);
        write_ok("timer irq enable", make_addr(SLOT_TIMER, 8'h00), 32'h1);
        waited = 0;
        while (!timer_irq && waited < int'(cmp) + 2) begin
            @(negedge clk);
            waited++;
        end
        if (!timer_irq) begin
            stop_with_fail("timer_irq did not rise within compare+2 cycles");
        end
        read_check("timer pending flag", make_addr(SLOT_TIMER, 8'h0c), 32'h1);
        write_ok("timer disable", make_addr(SLOT_TIMER, 8'h00), 32'h0);
        write_ok("timer clear pending", make_addr(SLOT_TIMER, 8'h0c), 32'h1);
        @(negedge clk);
        check_data("timer_irq after clear", '0, data_t'(timer_irq));

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
